// ==== fifoCfgPkg.sv ====
//----------------------------------------------------------------------
// async fifo configuration
// depth, word width, fill alert border and ram slice geometry
//----------------------------------------------------------------------
`default_nettype none

package fifoCfgPkg;

	// number of entries, one slot stays unused
	localparam int FIFO_DEPTH = 16;
	localparam int DATA_WIDTH = 8;
	// binary pointer width
	localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);
	// write side fill count that raises alert
	localparam int ALERT_BORDER = 12;

	// block ram aspect ratio picked by depth
	function automatic int sliceWidthFor(input int depth);
		int width;
		case (depth)
			256:     width = 16;
			512:     width = 8;
			1024:    width = 4;
			2048:    width = 2;
			4096:    width = 1;
			// shallow fifos map to narrow distributed slices
			default: width = 4;
		endcase
		return width;
	endfunction

	localparam int SLICE_WIDTH = sliceWidthFor(FIFO_DEPTH);
	// slices needed to cover one data word
	localparam int SLICE_COUNT = (DATA_WIDTH + SLICE_WIDTH - 1) / SLICE_WIDTH;
	// total ram width, may be wider than a word
	localparam int RAM_WIDTH = SLICE_WIDTH * SLICE_COUNT;

endpackage

`default_nettype wire

// ==== fifoTypesPkg.sv ====
//----------------------------------------------------------------------
// async fifo types
// pointer, data word, write request, read response and status flags
//----------------------------------------------------------------------
`default_nettype none

package fifoTypesPkg;

	import fifoCfgPkg::*;

	// binary or gray pointer, same width
	typedef logic [ADDR_WIDTH-1:0] fifoPtrT;

	// one data word
	typedef logic [DATA_WIDTH-1:0] fifoDataT;

	// write side request, iWCLK domain
	typedef struct packed {
		logic     wEn;
		fifoDataT wData;
	} fifoWrReqT;

	// read side response, iRCLK domain
	// rVld pulses one cycle after an accepted read
	typedef struct packed {
		logic     rVld;
		fifoDataT rData;
	} fifoRdRspT;

	// flag set as seen from outside
	typedef struct packed {
		logic full;
		logic empty;
		logic alert;
	} fifoStatT;

endpackage

`default_nettype wire

// ==== grayPtrSync.sv ====
//----------------------------------------------------------------------
// gray pointer synchronizer
// two flop capture of a gray pointer from the other clock domain,
// then decode back to binary in the destination domain
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module grayPtrSync
	import fifoCfgPkg::*;
	import fifoTypesPkg::*;
(
	input  logic    iRCLK,
	input  logic    inARST,
	input  fifoPtrT grayIn,
	output fifoPtrT binOut
);

	// first stage may go metastable, second is the stable copy
	fifoPtrT syncMeta;
	fifoPtrT syncGray;

	always_ff @(posedge iRCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			syncMeta <= '0;
			syncGray <= '0;
		end
		else
		begin
			syncMeta <= grayIn;
			syncGray <= syncMeta;
		end
	end

	// gray to binary, msb down through an xor chain
	always_comb
	begin
		fifoPtrT bin;
		bin[ADDR_WIDTH-1] = syncGray[ADDR_WIDTH-1];
		for (int i = ADDR_WIDTH - 2; i >= 0; i--)
		begin
			bin[i] = syncGray[i] ^ bin[i+1];
		end
		binOut = bin;
	end

	// gray steps may merge on a slower clock, but the pointer only moves forward
	assert property (@(posedge iRCLK) disable iff (!inARST)
		(binOut - $past(binOut)) < fifoPtrT'(FIFO_DEPTH / 2))
		else $error("synced pointer stepped backwards");

endmodule

`default_nettype wire

// ==== fifoWritePtr.sv ====
//----------------------------------------------------------------------
// fifo write side
// binary write pointer with registered gray copy, full flag,
// fill alert and qualification of the write strobe
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fifoWritePtr
	import fifoCfgPkg::*;
	import fifoTypesPkg::*;
(
	input  logic    iWCLK,
	input  logic    inARST,
	input  logic    wEn,
	input  fifoPtrT rPtrSyncBin,
	output fifoPtrT wPtrBin,
	output fifoPtrT wPtrGray,
	output logic    ramWe,
	output logic    full,
	output logic    alert
);

	fifoPtrT wPtrNext;
	fifoPtrT fillCnt;

	//------------------------------------------------------------------
	// flags, combinational on the local pointer
	//------------------------------------------------------------------
	assign wPtrNext = wPtrBin + fifoPtrT'(1);
	// one slot short of the read pointer counts as full
	assign full = (wPtrNext == rPtrSyncBin);
	// fill as seen from the write side, wraps mod depth
	assign fillCnt = wPtrBin - rPtrSyncBin;
	assign alert = (fillCnt >= fifoPtrT'(ALERT_BORDER));
	// write dropped while full
	assign ramWe = wEn & ~full;

	//------------------------------------------------------------------
	// pointer and gray copy
	//------------------------------------------------------------------
	always_ff @(posedge iWCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			wPtrBin  <= '0;
			wPtrGray <= '0;
		end
		else
		begin
			if (ramWe)
			begin
				wPtrBin <= wPtrNext;
			end
			// gray lags the binary pointer by one cycle
			wPtrGray <= wPtrBin ^ (wPtrBin >> 1);
		end
	end

	// read side overrun would make the fill jump up by more than one word
	assert property (@(posedge iWCLK) disable iff (!inARST)
		int'(fillCnt) <= int'($past(fillCnt)) + 1)
		else $error("write side fill grew by more than one word");

endmodule

`default_nettype wire

// ==== fifoReadPtr.sv ====
//----------------------------------------------------------------------
// fifo read side
// read pointer with registered gray copy, empty flag,
// read qualification and the read valid pulse
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fifoReadPtr
	import fifoTypesPkg::*;
(
	input  logic    iRCLK,
	input  logic    inARST,
	input  logic    rdEn,
	input  fifoPtrT wPtrSyncBin,
	output fifoPtrT rPtrBin,
	output fifoPtrT rPtrGray,
	output logic    ramRe,
	output logic    empty,
	output logic    rVld
);

	fifoPtrT rdFill;

	// fill as seen from the read side, wraps mod depth
	assign rdFill = wPtrSyncBin - rPtrBin;
	// pointers equal means nothing left to read
	assign empty = (wPtrSyncBin == rPtrBin);
	// read refused while empty
	assign ramRe = rdEn & ~empty;

	always_ff @(posedge iRCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			rPtrBin  <= '0;
			rPtrGray <= '0;
			rVld     <= 1'b0;
		end
		else
		begin
			if (ramRe)
			begin
				rPtrBin <= rPtrBin + fifoPtrT'(1);
			end
			rPtrGray <= rPtrBin ^ (rPtrBin >> 1);
			// ram output register is loaded on the same edge
			rVld <= ramRe;
		end
	end

	// write side overrun would make the fill drop by more than one word
	assert property (@(posedge iRCLK) disable iff (!inARST)
		int'(rdFill) + 1 >= int'($past(rdFill)))
		else $error("read side fill dropped by more than one word");

endmodule

`default_nettype wire

// ==== sdpBramSlice.sv ====
//----------------------------------------------------------------------
// simple dual port ram slice
// write port on iWCLK, registered read port on iRCLK
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sdpBramSlice
	import fifoCfgPkg::*;
	import fifoTypesPkg::*;
(
	input  logic                   iWCLK,
	input  logic                   iRCLK,
	input  logic                   we,
	input  fifoPtrT                wAddr,
	input  logic [SLICE_WIDTH-1:0] wData,
	input  logic                   re,
	input  fifoPtrT                rAddr,
	output logic [SLICE_WIDTH-1:0] rData
);

	// storage, inferred as block ram
	logic [SLICE_WIDTH-1:0] mem [FIFO_DEPTH];

	// write port
	always_ff @(posedge iWCLK)
	begin
		if (we)
		begin
			mem[wAddr] <= wData;
		end
	end

	// read port, output register holds between reads
	always_ff @(posedge iRCLK)
	begin
		if (re)
		begin
			rData <= mem[rAddr];
		end
	end

endmodule

`default_nettype wire

// ==== asyncFifo.sv ====
//----------------------------------------------------------------------
// async fifo top
// dual clock fifo, gray pointers cross through two flop syncs,
// data sits in a block ram built from narrow slices
// capacity is depth minus one
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module asyncFifo
	import fifoCfgPkg::*;
	import fifoTypesPkg::*;
(
	input  logic      iWCLK,
	input  logic      iRCLK,
	input  logic      inARST,
	// write domain
	input  fifoWrReqT wrReq,
	output logic      full,
	output logic      alert,
	// read domain
	input  logic      rdEn,
	output fifoRdRspT rdRsp,
	output logic      empty
);

	fifoPtrT wPtrBin;
	fifoPtrT wPtrGray;
	fifoPtrT wPtrSyncBin;
	fifoPtrT rPtrBin;
	fifoPtrT rPtrGray;
	fifoPtrT rPtrSyncBin;
	logic    ramWe;
	logic    ramRe;
	logic    rdVld;
	// word padded out to whole slices
	logic [RAM_WIDTH-1:0] ramWrData;
	logic [RAM_WIDTH-1:0] ramRdData;

	//------------------------------------------------------------------
	// write side, read pointer comes in on iWCLK
	//------------------------------------------------------------------
	fifoWritePtr u_wrPtr (
		.iWCLK       (iWCLK),
		.inARST      (inARST),
		.wEn         (wrReq.wEn),
		.rPtrSyncBin (rPtrSyncBin),
		.wPtrBin     (wPtrBin),
		.wPtrGray    (wPtrGray),
		.ramWe       (ramWe),
		.full        (full),
		.alert       (alert)
	);

	// read gray into the write domain
	grayPtrSync u_rToW (
		.iRCLK  (iWCLK),
		.inARST (inARST),
		.grayIn (rPtrGray),
		.binOut (rPtrSyncBin)
	);

	//------------------------------------------------------------------
	// read side, write pointer comes in on iRCLK
	//------------------------------------------------------------------
	grayPtrSync u_wToR (
		.iRCLK  (iRCLK),
		.inARST (inARST),
		.grayIn (wPtrGray),
		.binOut (wPtrSyncBin)
	);

	fifoReadPtr u_rdPtr (
		.iRCLK       (iRCLK),
		.inARST      (inARST),
		.rdEn        (rdEn),
		.wPtrSyncBin (wPtrSyncBin),
		.rPtrBin     (rPtrBin),
		.rPtrGray    (rPtrGray),
		.ramRe       (ramRe),
		.empty       (empty),
		.rVld        (rdVld)
	);

	//------------------------------------------------------------------
	// sliced ram, each slice takes its own bit field
	//------------------------------------------------------------------
	assign ramWrData = RAM_WIDTH'(wrReq.wData);

	for (genvar s = 0; s < SLICE_COUNT; s++)
	begin : genSlice
		sdpBramSlice u_slice (
			.iWCLK (iWCLK),
			.iRCLK (iRCLK),
			.we    (ramWe),
			.wAddr (wPtrBin),
			.wData (ramWrData[s*SLICE_WIDTH +: SLICE_WIDTH]),
			.re    (ramRe),
			.rAddr (rPtrBin),
			.rData (ramRdData[s*SLICE_WIDTH +: SLICE_WIDTH])
		);
	end

	// valid pulse lines up with the ram output register
	assign rdRsp = '{rVld: rdVld, rData: ramRdData[DATA_WIDTH-1:0]};

endmodule

`default_nettype wire

// ==== tbClockGen.sv ====
//----------------------------------------------------------------------
// testbench clock source
// free running clock, low at time zero, given period in ns
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
	parameter real PERIOD_NS = 4.0
)(
	output logic clk
);

	// first rising edge at half a period
	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(PERIOD_NS / 2.0) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

// ==== asyncFifoTb.sv ====
//----------------------------------------------------------------------
// async fifo testbench
// table driven write bursts, read bursts and concurrent traffic,
// read data checked against a model queue, flags after settling
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module asyncFifoTb
	import fifoCfgPkg::*;
	import fifoTypesPkg::*;
();

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_BOTH} opT;

	// one table row, expected flags after the settling wait
	typedef struct {
		string    name;
		opT       op;
		int       count;
		fifoStatT exp;
	} rowT;

	localparam int NUM_ROWS = 10;

	logic      iWCLK;
	logic      iRCLK;
	logic      inARST;
	fifoWrReqT wrReq;
	logic      full;
	logic      alert;
	logic      rdEn;
	fifoRdRspT rdRsp;
	logic      empty;

	rowT         rows [NUM_ROWS];
	fifoDataT    model [$];
	int unsigned lcgState;
	int          cycleCnt = 0;
	int          cycleLimit = 0;

	//------------------------------------------------------------------
	// clocks and DUT
	//------------------------------------------------------------------
	tbClockGen #(.PERIOD_NS(4.0)) u_rClk (.clk(iRCLK));
	tbClockGen #(.PERIOD_NS(6.0)) u_wClk (.clk(iWCLK));

	asyncFifo u_dut (
		.iWCLK  (iWCLK),
		.iRCLK  (iRCLK),
		.inARST (inARST),
		.wrReq  (wrReq),
		.full   (full),
		.alert  (alert),
		.rdEn   (rdEn),
		.rdRsp  (rdRsp),
		.empty  (empty)
	);

	//------------------------------------------------------------------
	// helpers
	//------------------------------------------------------------------
	task automatic stopOnError(string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkData(string name, fifoDataT exp, fifoDataT act);
		if (exp !== act)
		begin
			stopOnError($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic checkStat(string name, fifoStatT exp, fifoStatT act);
		if (exp !== act)
		begin
			stopOnError($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	task automatic checkVld(string name, logic exp, logic act);
		if (exp !== act)
		begin
			stopOnError($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	// full, empty, alert in struct order
	function automatic fifoStatT flagsOf(logic f, logic e, logic a);
		return '{full: f, empty: e, alert: a};
	endfunction

	// lcg, upper bits give the data word
	function automatic fifoDataT nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[23:16];
	endfunction

	task automatic popAndCheck(string name);
		if (model.size() == 0)
		begin
			stopOnError($sformatf("%s: read valid seen with no word left to read", name));
		end
		else
		begin
			checkData(name, model.pop_front(), rdRsp.rData);
		end
	endtask

	// one word per iWCLK cycle, model keeps depth minus one words
	task automatic writeBurst(int count);
		for (int i = 0; i < count; i++)
		begin
			@(posedge iWCLK);
			#1;
			wrReq.wEn   = 1'b1;
			wrReq.wData = nextRand();
			if (model.size() < FIFO_DEPTH - 1)
			begin
				model.push_back(wrReq.wData);
			end
		end
		@(posedge iWCLK);
		#1;
		wrReq.wEn = 1'b0;
	endtask

	// fixed mode reads for count cycles, taken reads come from the model
	// concurrent mode reads until count words came back
	task automatic readSide(string name, int count, bit concurrent);
		int   cycles;
		int   got;
		logic takePrev;
		cycles   = 0;
		got      = 0;
		takePrev = 1'b0;
		do
		begin
			@(posedge iRCLK);
			#1;
			// valid exactly one cycle after a taken read
			if (concurrent)
			begin
				// refused reads are fine, a valid nobody asked for is not
				if (!takePrev)
				begin
					checkVld(name, 1'b0, rdRsp.rVld);
				end
			end
			else
			begin
				checkVld(name, takePrev, rdRsp.rVld);
			end
			if (rdRsp.rVld)
			begin
				popAndCheck(name);
				got++;
			end
			if (concurrent)
			begin
				rdEn = (got < count);
			end
			else
			begin
				rdEn = (cycles < count);
			end
			// fixed mode knows the fill, concurrent mode only the request
			takePrev = rdEn && (concurrent || model.size() > 0);
			cycles++;
		end
		while (rdEn || takePrev);
	endtask

	//------------------------------------------------------------------
	// timeout on iRCLK cycles
	//------------------------------------------------------------------
	always @(posedge iRCLK)
	begin
		cycleCnt = cycleCnt + 1;
		if (cycleLimit > 0 && cycleCnt >= cycleLimit)
		begin
			$display("timeout: run did not finish within %0d read clock cycles", cycleLimit);
			$display("Testbench failed");
			$fatal(1, "timeout");
		end
	end

	//------------------------------------------------------------------
	// main sequence
	//------------------------------------------------------------------
	initial
	begin
		wrReq    = '0;
		rdEn     = 1'b0;
		inARST   = 1'b0;
		lcgState = 1;

		rows[0] = '{"wrFour",       OP_WRITE,  4, flagsOf(1'b0, 1'b0, 1'b0)};
		rows[1] = '{"rdFour",       OP_READ,   4, flagsOf(1'b0, 1'b1, 1'b0)};
		rows[2] = '{"rdWhileEmpty", OP_READ,   3, flagsOf(1'b0, 1'b1, 1'b0)};
		rows[3] = '{"wrBelowAlert", OP_WRITE, 11, flagsOf(1'b0, 1'b0, 1'b0)};
		// fill reaches the border
		rows[4] = '{"wrAlertOn",    OP_WRITE,  1, flagsOf(1'b0, 1'b0, 1'b1)};
		rows[5] = '{"rdAlertOff",   OP_READ,   1, flagsOf(1'b0, 1'b0, 1'b0)};
		rows[6] = '{"rdDrain",      OP_READ,  11, flagsOf(1'b0, 1'b1, 1'b0)};
		// sixteenth write is dropped
		rows[7] = '{"wrPastFull",   OP_WRITE, 16, flagsOf(1'b1, 1'b0, 1'b1)};
		rows[8] = '{"rdFifteen",    OP_READ,  20, flagsOf(1'b0, 1'b1, 1'b0)};
		rows[9] = '{"concurrent",   OP_BOTH,  40, flagsOf(1'b0, 1'b1, 1'b0)};

		// limit from the total count of the table
		cycleLimit = 200;
		foreach (rows[i])
		begin
			cycleLimit += 20 * rows[i].count;
		end

		// reset for two read clock cycles
		repeat (2) @(posedge iRCLK);
		#1;
		inARST = 1'b1;
		@(posedge iRCLK);
		#1;
		checkStat("afterReset", flagsOf(1'b0, 1'b1, 1'b0), flagsOf(full, empty, alert));
		checkVld("afterReset", 1'b0, rdRsp.rVld);

		foreach (rows[i])
		begin
			case (rows[i].op)
				OP_WRITE: writeBurst(rows[i].count);
				OP_READ:  readSide(rows[i].name, rows[i].count, 1'b0);
				default:
				begin
					fork
						writeBurst(rows[i].count);
						readSide(rows[i].name, rows[i].count, 1'b1);
					join
				end
			endcase
			// pointers cross both ways before flags are compared
			repeat (4) @(posedge iWCLK);
			#1;
			checkStat(rows[i].name, rows[i].exp, flagsOf(full, empty, alert));
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== asyncFifo.f ====
fifoCfgPkg.sv
fifoTypesPkg.sv
grayPtrSync.sv
fifoWritePtr.sv
fifoReadPtr.sv
sdpBramSlice.sv
asyncFifo.sv
tbClockGen.sv
asyncFifoTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# build the async FIFO testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f asyncFifo.f --top-module asyncFifoTb -o simv > build.log 2>&1 \
	|| { cat build.log; echo "build error"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

# the fail message decides, a missing pass message counts as failure too
! grep -q "Testbench failed" sim.log && grep -q "Testbench passed" sim.log \
	&& exit 0 || exit 1
